/* Bender.yml */
package:
  name: board_ctrl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/cfg_pkg.sv
      - rtl/byte_link_if.sv
      - rtl/mmc_reader.sv
      - rtl/cfg_fifo.sv
      - rtl/v5c_serial.sv
      - rtl/lb_regs.sv
      - rtl/board_ctrl_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - verif/tb_models.sv
      - verif/tb_board_ctrl.sv

/* project.f */
+incdir+rtl
rtl/cfg_pkg.sv
rtl/byte_link_if.sv
rtl/mmc_reader.sv
rtl/cfg_fifo.sv
rtl/v5c_serial.sv
rtl/lb_regs.sv
rtl/board_ctrl_top.sv
verif/tb_models.sv
verif/tb_board_ctrl.sv

/* rtl/board_ctrl_top.sv */
`timescale 1ns/10ps

module board_ctrl_top (
  input  logic       clk_master,
  input  logic       reset_i,
  input  logic       lb_stb_i,
  input  logic       lb_we_i,
  input  logic [2:0] lb_adr_i,
  input  logic [7:0] lb_dat_i,
  output logic [7:0] lb_dat_o,
  input  logic [7:0] mmc_data_i,
  output logic       mmc_clk_o,
  output logic       mmc_cmd_o,
  input  logic       v5c_init_n_i,
  input  logic       v5c_done_i,
  output logic       v5c_prog_n_o,
  output logic       v5c_din_o,
  output logic       v5c_cclk_o,
  output logic       v5c_cclk_en_n_o
);

  logic                 start;
  logic                 abort;
  logic                 fifo_flush;
  cfg_pkg::cfg_status_t status;
  logic [15:0]          count;

  byte_link_if rd_link ();  // Card reader to FIFO
  byte_link_if cf_link ();  // FIFO to configurator

  assign fifo_flush = abort | status.error;  // Drop buffered bytes of a dead load

  mmc_reader mmc_reader_inst (
    .clk(clk_master), .reset_i(reset_i),
    .start_i(start), .abort_i(abort), .cfg_error_i(status.error),
    .mmc_data_i(mmc_data_i),
    .mmc_clk_o(mmc_clk_o), .mmc_cmd_o(mmc_cmd_o),
    .link(rd_link.source)
  );

  cfg_fifo cfg_fifo_inst (
    .clk(clk_master), .reset_i(reset_i),
    .flush_i(fifo_flush),
    .in_link(rd_link.sink),
    .out_link(cf_link.source)
  );

  v5c_serial v5c_serial_inst (
    .clk(clk_master), .reset_i(reset_i),
    .start_i(start), .abort_i(abort),
    .v5c_init_n_i(v5c_init_n_i), .v5c_done_i(v5c_done_i),
    .v5c_prog_n_o(v5c_prog_n_o), .v5c_din_o(v5c_din_o),
    .v5c_cclk_o(v5c_cclk_o), .v5c_cclk_en_n_o(v5c_cclk_en_n_o),
    .status_o(status), .count_o(count),
    .link(cf_link.sink)
  );

  lb_regs lb_regs_inst (
    .clk(clk_master), .reset_i(reset_i),
    .lb_stb_i(lb_stb_i), .lb_we_i(lb_we_i),
    .lb_adr_i(lb_adr_i), .lb_dat_i(lb_dat_i), .lb_dat_o(lb_dat_o),
    .status_i(status), .count_i(count),
    .start_o(start), .abort_o(abort)
  );

endmodule

/* rtl/byte_link_if.sv */
`timescale 1ns/10ps

// Byte transfer with a four-phase req/ack handshake
interface byte_link_if;

  logic       req;   // Source has a byte on data
  logic       ack;   // Sink has taken the byte
  logic [7:0] data;
  logic       last;  // Marks the final byte of an image

  modport source (
    output req,
    output data,
    output last,
    input  ack
  );

  modport sink (
    input  req,
    input  data,
    input  last,
    output ack
  );

endinterface

/* rtl/cfg_defs.svh */
`ifndef CFG_DEFS_SVH
`define CFG_DEFS_SVH

// Bytes in one configuration image read from the card in boot mode
`define CFG_IMAGE_BYTES 64

// Entries in the byte buffer between card and FPGA, a power of two
`define CFG_FIFO_DEPTH 8

// Cycles of clk_master that PROG_B is held low to clear the FPGA
`define CFG_PROG_CYCLES 16

// Extra CCLK pulses after the last byte while waiting for DONE
`define CFG_DONE_CCLKS 32

`endif

/* rtl/cfg_fifo.sv */
`timescale 1ns/10ps
`include "cfg_defs.svh"

module cfg_fifo (
  input  logic        clk,
  input  logic        reset_i,
  input  logic        flush_i,
  byte_link_if.sink   in_link,
  byte_link_if.source out_link
);

  localparam int DEPTH = `CFG_FIFO_DEPTH;
  localparam int AW    = $clog2(DEPTH);
  localparam int CNTW  = AW + 1;

  logic [8:0]      mem_q [DEPTH];  // {last, data}
  logic [AW-1:0]   wr_ptr_q;
  logic [AW-1:0]   rd_ptr_q;
  logic [CNTW-1:0] count_q;
  logic            in_req_q;
  logic            in_ack_q;
  logic            out_req_q;
  logic            full;
  logic            empty;
  logic            push;
  logic            pop;

  assign full  = (count_q == CNTW'(DEPTH));
  assign empty = (count_q == '0);

  // Delayed req gives the ack two cycles after the source raised req
  assign push = in_req_q && in_link.req && !in_ack_q && !full;
  assign pop  = out_req_q && out_link.ack;

  assign in_link.ack  = in_ack_q;
  assign out_link.req = out_req_q;
  assign {out_link.last, out_link.data} = mem_q[rd_ptr_q];  // Head entry, held while req is up

  always_ff @(posedge clk) begin
    if (reset_i || flush_i) begin
      in_req_q  <= 1'b0;
      in_ack_q  <= 1'b0;
      out_req_q <= 1'b0;
      wr_ptr_q  <= '0;
      rd_ptr_q  <= '0;
      count_q   <= '0;
    end else begin
      in_req_q <= in_link.req;

      if (push) begin
        in_ack_q <= 1'b1;
      end else if (in_ack_q && !in_link.req) begin
        in_ack_q <= 1'b0;  // Phase 4 on the input side
      end

      if (pop) begin
        out_req_q <= 1'b0;
      end else if (!out_req_q && !empty && !out_link.ack) begin
        out_req_q <= 1'b1;
      end

      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;  // Wraps since depth is a power of two
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end

      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem_q[wr_ptr_q] <= {in_link.last, in_link.data};
    end
  end

  // An acknowledged input byte always landed in a free slot
  assert property (@(posedge clk) disable iff (reset_i || flush_i)
    $rose(in_link.ack) |-> $past(count_q) < CNTW'(DEPTH));

  // A completed output transfer always took a stored byte
  assert property (@(posedge clk) disable iff (reset_i || flush_i)
    $fell(out_link.req) |-> $past(count_q) != '0);

endmodule

/* rtl/cfg_pkg.sv */
package cfg_pkg;

  // Local bus register map
  typedef enum logic [2:0] {
    REG_CTRL     = 3'd0,  // Bit 0 starts a boot, bit 1 aborts it
    REG_STATUS   = 3'd1,  // Reads cfg_status_t
    REG_COUNT_LO = 3'd2,  // Shifted byte count, low byte
    REG_COUNT_HI = 3'd3   // Shifted byte count, high byte
  } lb_reg_e;

  // States of the slave-serial configuration FSM
  typedef enum logic [2:0] {
    IDLE      = 3'd0,
    PROG      = 3'd1,  // PROG_B held low
    WAIT_INIT = 3'd2,  // Waiting for the FPGA to release INIT_B
    SHIFT     = 3'd3,  // Image bytes going out on DIN
    WAIT_DONE = 3'd4,  // Extra CCLKs until DONE rises
    DONE      = 3'd5,
    ERROR     = 3'd6
  } boot_state_e;

  // Boot status as seen by the host
  typedef struct packed {
    logic [3:0] pad;    // Reads as zero
    logic       init;   // Live copy of INIT_B
    logic       error;  // Load error, DONE timeout or host abort
    logic       done;   // DONE was seen
    logic       busy;   // A boot is running
  } cfg_status_t;

endpackage

/* rtl/lb_regs.sv */
`timescale 1ns/10ps

module lb_regs (
  input  logic                 clk,
  input  logic                 reset_i,
  input  logic                 lb_stb_i,
  input  logic                 lb_we_i,
  input  logic [2:0]           lb_adr_i,
  input  logic [7:0]           lb_dat_i,
  input  cfg_pkg::cfg_status_t status_i,
  input  logic [15:0]          count_i,
  output logic [7:0]           lb_dat_o,
  output logic                 start_o,
  output logic                 abort_o
);

  logic ctrl_wr;

  assign ctrl_wr = lb_stb_i && lb_we_i && (lb_adr_i == cfg_pkg::REG_CTRL);

  always_ff @(posedge clk) begin
    if (reset_i) begin
      start_o <= 1'b0;
      abort_o <= 1'b0;
    end else begin
      // A running boot swallows further starts, back-to-back writes give one pulse
      start_o <= ctrl_wr && lb_dat_i[0] && !status_i.busy && !start_o;
      abort_o <= ctrl_wr && lb_dat_i[1];
    end
  end

  always_comb begin
    lb_dat_o = 8'h00;
    if (lb_stb_i) begin
      case (lb_adr_i)
        cfg_pkg::REG_STATUS:   lb_dat_o = status_i;
        cfg_pkg::REG_COUNT_LO: lb_dat_o = count_i[7:0];
        cfg_pkg::REG_COUNT_HI: lb_dat_o = count_i[15:8];
        default:               lb_dat_o = 8'h00;  // Control bits self-clear and read zero
      endcase
    end
  end

endmodule

/* rtl/mmc_reader.sv */
`timescale 1ns/10ps
`include "cfg_defs.svh"

module mmc_reader (
  input  logic        clk,
  input  logic        reset_i,
  input  logic        start_i,
  input  logic        abort_i,
  input  logic        cfg_error_i,
  input  logic [7:0]  mmc_data_i,
  output logic        mmc_clk_o,
  output logic        mmc_cmd_o,
  byte_link_if.source link
);

  localparam int CW = $clog2(`CFG_IMAGE_BYTES + 1);

  logic          run_q;
  logic          mclk_q;
  logic          req_q;
  logic          last_q;
  logic [7:0]    data_q;
  logic [CW-1:0] bytes_q;
  logic          stop;
  logic          capture;
  logic          link_free;

  assign stop      = run_q && (abort_i || cfg_error_i);
  assign capture   = run_q && mclk_q && !stop;  // Card clock is high, DAT settled after its rise
  assign link_free = !req_q && !link.ack;       // Previous byte fully handed over

  assign mmc_cmd_o = !run_q;  // Boot mode keeps CMD low for the whole read
  assign mmc_clk_o = mclk_q;

  assign link.req  = req_q;
  assign link.data = data_q;
  assign link.last = last_q;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      run_q   <= 1'b0;
      mclk_q  <= 1'b0;
      req_q   <= 1'b0;
      last_q  <= 1'b0;
      bytes_q <= '0;
    end else if (stop) begin
      run_q  <= 1'b0;  // Releases CMD at once
      mclk_q <= 1'b0;
      req_q  <= 1'b0;
    end else if (!run_q) begin
      if (start_i) begin
        run_q   <= 1'b1;
        bytes_q <= '0;
        last_q  <= 1'b0;
      end
    end else if (capture) begin
      mclk_q  <= 1'b0;  // Clock parks low until the link frees up
      req_q   <= 1'b1;
      last_q  <= (bytes_q == CW'(`CFG_IMAGE_BYTES - 1));
      bytes_q <= bytes_q + 1'b1;
    end else if (req_q) begin
      if (link.ack) begin
        req_q <= 1'b0;  // Phase 3
      end
    end else if (link_free) begin
      if (last_q) begin
        run_q <= 1'b0;  // Whole image handed over
      end else begin
        mclk_q <= 1'b1;  // Ask the card for the next byte
      end
    end
  end

  always_ff @(posedge clk) begin
    if (capture) begin
      data_q <= mmc_data_i;
    end
  end

  // The byte offered to the FIFO must not move before it is acknowledged
  assert property (@(posedge clk) disable iff (reset_i)
    link.req && $past(link.req) |-> $stable(link.data) && $stable(link.last));

endmodule

/* rtl/v5c_serial.sv */
`timescale 1ns/10ps
`include "cfg_defs.svh"

module v5c_serial (
  input  logic                 clk,
  input  logic                 reset_i,
  input  logic                 start_i,
  input  logic                 abort_i,
  input  logic                 v5c_init_n_i,
  input  logic                 v5c_done_i,
  output logic                 v5c_prog_n_o,
  output logic                 v5c_din_o,
  output logic                 v5c_cclk_o,
  output logic                 v5c_cclk_en_n_o,
  output cfg_pkg::cfg_status_t status_o,
  output logic [15:0]          count_o,
  byte_link_if.sink            link
);

  localparam int TW = $clog2(`CFG_PROG_CYCLES + `CFG_DONE_CCLKS + 1);

  cfg_pkg::boot_state_e state_q;

  logic [1:0]    init_sync_q;
  logic [1:0]    done_sync_q;
  logic          prog_n_q;
  logic          cclk_q;
  logic          ack_q;
  logic          have_q;  // A byte sits in the shift register
  logic          last_q;
  logic [2:0]    bit_q;
  logic [7:0]    sr_q;
  logic [TW-1:0] timer_q;
  logic [15:0]   count_q;
  logic          init_ok;
  logic          done_ok;
  logic          busy;
  logic          loading;
  logic          take;
  logic          fall;
  logic          timeout;
  logic          fail;

  assign init_ok = init_sync_q[1];
  assign done_ok = done_sync_q[1];
  assign busy    = state_q inside {cfg_pkg::PROG, cfg_pkg::WAIT_INIT,
                                   cfg_pkg::SHIFT, cfg_pkg::WAIT_DONE};
  assign loading = (state_q == cfg_pkg::SHIFT) || (state_q == cfg_pkg::WAIT_DONE);

  assign take    = (state_q == cfg_pkg::SHIFT) && !have_q && !ack_q && link.req;
  assign fall    = (state_q == cfg_pkg::SHIFT) && have_q && cclk_q;  // CCLK about to drop
  assign timeout = (state_q == cfg_pkg::WAIT_DONE) && cclk_q && !done_ok &&
                   (timer_q == TW'(`CFG_DONE_CCLKS - 1));
  assign fail    = (busy && abort_i) || (loading && !init_ok) || timeout;

  assign v5c_prog_n_o    = prog_n_q;
  assign v5c_din_o       = sr_q[7];  // MSB first
  assign v5c_cclk_o      = cclk_q;
  assign v5c_cclk_en_n_o = !busy;
  assign count_o         = count_q;
  assign link.ack        = ack_q;

  always_comb begin
    status_o       = '0;
    status_o.busy  = busy;
    status_o.done  = (state_q == cfg_pkg::DONE);
    status_o.error = (state_q == cfg_pkg::ERROR);
    status_o.init  = init_ok;
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      init_sync_q <= 2'b00;
      done_sync_q <= 2'b00;
    end else begin
      init_sync_q <= {init_sync_q[0], v5c_init_n_i};
      done_sync_q <= {done_sync_q[0], v5c_done_i};
    end
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state_q  <= cfg_pkg::IDLE;
      prog_n_q <= 1'b0;  // FPGA stays cleared through board reset
      cclk_q   <= 1'b0;
      ack_q    <= 1'b0;
      have_q   <= 1'b0;
      last_q   <= 1'b0;
      bit_q    <= '0;
      timer_q  <= '0;
      count_q  <= '0;
    end else begin
      if (ack_q && !link.req) begin
        ack_q <= 1'b0;  // Phase 4
      end

      if (fail) begin
        state_q  <= cfg_pkg::ERROR;
        prog_n_q <= 1'b0;  // Hold the FPGA cleared after a failed load
        cclk_q   <= 1'b0;
        have_q   <= 1'b0;
      end else begin
        case (state_q)
          cfg_pkg::IDLE, cfg_pkg::DONE, cfg_pkg::ERROR: begin
            if (start_i) begin
              state_q  <= cfg_pkg::PROG;
              prog_n_q <= 1'b0;
              timer_q  <= '0;
              count_q  <= '0;
              have_q   <= 1'b0;
            end else if (state_q == cfg_pkg::IDLE) begin
              prog_n_q <= 1'b1;
            end
          end
          cfg_pkg::PROG: begin
            timer_q <= timer_q + 1'b1;
            if (timer_q == TW'(`CFG_PROG_CYCLES - 1)) begin
              prog_n_q <= 1'b1;
              state_q  <= cfg_pkg::WAIT_INIT;
            end
          end
          cfg_pkg::WAIT_INIT: begin
            if (init_ok) begin
              state_q <= cfg_pkg::SHIFT;  // FPGA finished clearing its memory
            end
          end
          cfg_pkg::SHIFT: begin
            if (take) begin
              ack_q  <= 1'b1;
              have_q <= 1'b1;
              last_q <= link.last;
              bit_q  <= '0;
            end else if (have_q && !cclk_q) begin
              cclk_q <= 1'b1;  // FPGA samples DIN on this rise
            end else if (fall) begin
              cclk_q <= 1'b0;
              bit_q  <= bit_q + 1'b1;
              if (bit_q == 3'd7) begin
                have_q  <= 1'b0;
                count_q <= count_q + 1'b1;
                if (last_q) begin
                  state_q <= cfg_pkg::WAIT_DONE;
                  timer_q <= '0;
                end
              end
            end
          end
          cfg_pkg::WAIT_DONE: begin
            if (done_ok) begin
              state_q <= cfg_pkg::DONE;
              cclk_q  <= 1'b0;
            end else if (!cclk_q) begin
              cclk_q <= 1'b1;
            end else begin
              cclk_q  <= 1'b0;
              timer_q <= timer_q + 1'b1;
            end
          end
          default: state_q <= cfg_pkg::IDLE;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      sr_q <= link.data;
    end else if (fall) begin
      sr_q <= {sr_q[6:0], 1'b0};  // Next bit appears while CCLK is low
    end
  end

  // PROG_B keeps the FPGA cleared for as long as the board sits in reset
  assert property (@(posedge clk) reset_i && $past(reset_i) |-> !v5c_prog_n_o);

endmodule

/* verif/tb_board_ctrl.sv */
`timescale 1ns/10ps
`include "cfg_defs.svh"

module tb_board_ctrl;

  localparam int CYCLE_LIMIT = 6 * `CFG_IMAGE_BYTES * 24 + 2000;
  localparam int BOOT_LIMIT  = `CFG_IMAGE_BYTES * 24 + 1000;

  logic       clk_master;
  logic       reset;
  logic       lb_stb;
  logic       lb_we;
  logic [2:0] lb_adr;
  logic [7:0] lb_dat_w;
  logic [7:0] lb_dat_r;
  logic [7:0] mmc_data;
  logic       mmc_clk;
  logic       mmc_cmd;
  logic       v5c_init_n;
  logic       v5c_done;
  logic       v5c_prog_n;
  logic       v5c_din;
  logic       v5c_cclk;
  logic       v5c_cclk_en_n;
  int         init_wait;
  int         fail_after;
  int         cycles;
  int         mismatch_errs;
  int         other_errs;

  board_ctrl_top dut0 (
    .clk_master(clk_master), .reset_i(reset),
    .lb_stb_i(lb_stb), .lb_we_i(lb_we), .lb_adr_i(lb_adr),
    .lb_dat_i(lb_dat_w), .lb_dat_o(lb_dat_r),
    .mmc_data_i(mmc_data), .mmc_clk_o(mmc_clk), .mmc_cmd_o(mmc_cmd),
    .v5c_init_n_i(v5c_init_n), .v5c_done_i(v5c_done),
    .v5c_prog_n_o(v5c_prog_n), .v5c_din_o(v5c_din),
    .v5c_cclk_o(v5c_cclk), .v5c_cclk_en_n_o(v5c_cclk_en_n)
  );

  mmc_boot_model card0 (.mmc_clk_i(mmc_clk), .mmc_cmd_i(mmc_cmd), .mmc_data_o(mmc_data));

  fpga_ss_model fpga0 (
    .prog_n_i(v5c_prog_n), .cclk_i(v5c_cclk), .din_i(v5c_din),
    .init_wait_i(init_wait), .fail_after_i(fail_after),
    .init_n_o(v5c_init_n), .done_o(v5c_done)
  );

  always #4 clk_master = ~clk_master;

  always @(posedge clk_master) begin
    cycles = cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Run stopped after %0d cycles, a boot or handshake is stuck", cycles);
      $display("Errors: %0d mismatches, %0d other failures", mismatch_errs, other_errs + 1);
      $display("Simulation failed");
      $finish;
    end
  end

  function automatic cfg_pkg::cfg_status_t status_of(input logic busy, input logic done,
                                                     input logic error, input logic init);
    cfg_pkg::cfg_status_t s;
    s       = '0;
    s.busy  = busy;
    s.done  = done;
    s.error = error;
    s.init  = init;
    return s;
  endfunction

  task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) begin
      $display("mismatch %s: got %h expected %h", name, got, exp);
      mismatch_errs++;
    end
  endtask

  task automatic check_status(input string name, input cfg_pkg::cfg_status_t got,
                              input cfg_pkg::cfg_status_t exp);
    if (got !== exp) begin
      $display("mismatch %s: got %h expected %h", name, got, exp);
      mismatch_errs++;
    end
  endtask

  task automatic check_count(input string name, input logic [15:0] got, input logic [15:0] exp);
    if (got !== exp) begin
      $display("mismatch %s: got %h expected %h", name, got, exp);
      mismatch_errs++;
    end
  endtask

  task automatic bus_write(input cfg_pkg::lb_reg_e adr, input logic [7:0] dat);
    @(posedge clk_master);
    #1;
    lb_stb   = 1'b1;
    lb_we    = 1'b1;
    lb_adr   = adr;
    lb_dat_w = dat;
    @(posedge clk_master);  // Write lands on this edge
    #1;
    lb_stb = 1'b0;
    lb_we  = 1'b0;
  endtask

  task automatic bus_read(input cfg_pkg::lb_reg_e adr, output logic [7:0] dat);
    @(posedge clk_master);
    #1;
    lb_stb = 1'b1;
    lb_we  = 1'b0;
    lb_adr = adr;
    #4;
    dat = lb_dat_r;  // Combinational read data, settled mid cycle
    @(posedge clk_master);
    #1;
    lb_stb = 1'b0;
  endtask

  task automatic read_status(output cfg_pkg::cfg_status_t st);
    logic [7:0] d;
    bus_read(cfg_pkg::REG_STATUS, d);
    st = d;
  endtask

  task automatic read_count(output logic [15:0] cnt);
    logic [7:0] lo;
    logic [7:0] hi;
    bus_read(cfg_pkg::REG_COUNT_LO, lo);
    bus_read(cfg_pkg::REG_COUNT_HI, hi);
    cnt = {hi, lo};
  endtask

  // Start write, then CMD and PROG_B go low on the next cycle
  task automatic start_boot();
    int low;
    low = 0;
    bus_write(cfg_pkg::REG_CTRL, 8'h01);
    @(posedge clk_master);
    #1;
    check_byte("mmc_cmd_o after start", {7'd0, mmc_cmd}, 8'h00);
    while (!v5c_prog_n && low < 4 * `CFG_PROG_CYCLES) begin
      @(posedge clk_master);
      #1;
      low++;
    end
    check_count("v5c_prog_n_o low cycles", 16'(low), 16'(`CFG_PROG_CYCLES));
    check_byte("v5c_cclk_en_n_o during boot", {7'd0, v5c_cclk_en_n}, 8'h00);
  endtask

  task automatic wait_boot_end();
    cfg_pkg::cfg_status_t st;
    int polls;
    polls = 0;
    read_status(st);
    while (st.busy && polls < BOOT_LIMIT / 2) begin
      read_status(st);
      polls++;
    end
    if (st.busy) begin
      $display("Boot still busy after %0d cycles", BOOT_LIMIT);
      other_errs++;
    end
  endtask

  task automatic wait_rx_bytes(input int n);
    int waited;
    waited = 0;
    while (fpga0.rx_count < n && waited < BOOT_LIMIT) begin
      @(posedge clk_master);
      waited++;
    end
    if (fpga0.rx_count < n) begin
      $display("FPGA model received only %0d of %0d bytes", fpga0.rx_count, n);
      other_errs++;
    end
  endtask

  task automatic compare_image(input int n);
    for (int i = 0; i < n; i++) begin
      check_byte($sformatf("image byte %0d", i), fpga0.rx_mem[i], card0.sent[i]);
    end
  endtask

  task automatic expect_good_finish();
    cfg_pkg::cfg_status_t st;
    logic [15:0] cnt;
    wait_boot_end();
    check_byte("v5c_cclk_en_n_o after boot", {7'd0, v5c_cclk_en_n}, 8'h01);
    read_status(st);
    check_status("status", st, status_of(1'b0, 1'b1, 1'b0, 1'b1));
    read_count(cnt);
    check_count("count", cnt, 16'(`CFG_IMAGE_BYTES));
    check_byte("mmc_cmd_o after boot", {7'd0, mmc_cmd}, 8'h01);
    check_count("card bytes sent", 16'(card0.sent_count), 16'(`CFG_IMAGE_BYTES));
    check_count("fpga bytes received", 16'(fpga0.rx_count), 16'(`CFG_IMAGE_BYTES));
    compare_image(`CFG_IMAGE_BYTES);
  endtask

  task automatic verify_reset();
    cfg_pkg::cfg_status_t st;
    logic [15:0] cnt;
    repeat (4) @(posedge clk_master);
    #1;
    check_byte("v5c_prog_n_o in reset", {7'd0, v5c_prog_n}, 8'h00);
    repeat (4) @(posedge clk_master);
    #1;
    reset = 1'b0;
    @(posedge clk_master);
    #1;
    check_byte("v5c_prog_n_o", {7'd0, v5c_prog_n}, 8'h01);
    check_byte("mmc_cmd_o", {7'd0, mmc_cmd}, 8'h01);
    check_byte("mmc_clk_o", {7'd0, mmc_clk}, 8'h00);
    check_byte("v5c_cclk_o", {7'd0, v5c_cclk}, 8'h00);
    check_byte("v5c_cclk_en_n_o", {7'd0, v5c_cclk_en_n}, 8'h01);
    read_status(st);
    check_status("status after reset", st, status_of(1'b0, 1'b0, 1'b0, 1'b0));
    read_count(cnt);
    check_count("count after reset", cnt, 16'h0000);
    wait (v5c_init_n == 1'b1);  // FPGA model settles before the first boot
  endtask

  task automatic run_full_boot();
    start_boot();
    expect_good_finish();
  endtask

  // FIFO fills and the card clock stalls while INIT_B is held low
  task automatic slow_init_boot();
    init_wait = 3000;
    start_boot();
    @(posedge v5c_init_n);
    check_count("CCLK pulses before INIT_B", 16'(fpga0.cclk_count), 16'h0000);
    expect_good_finish();
    init_wait = 200;
  endtask

  task automatic load_error_boot();
    cfg_pkg::cfg_status_t st;
    logic [15:0] cnt;
    fail_after = 20;
    start_boot();
    wait_boot_end();
    read_status(st);
    check_status("status after load error", st, status_of(1'b0, 1'b0, 1'b1, 1'b0));
    check_byte("mmc_cmd_o after load error", {7'd0, mmc_cmd}, 8'h01);
    read_count(cnt);
    if (cnt > 16'd21) begin
      $display("mismatch count: got %h expected at most %h", cnt, 16'd21);
      mismatch_errs++;
    end
    compare_image(fpga0.rx_count);
    fail_after = -1;
  endtask

  task automatic host_abort_boot();
    cfg_pkg::cfg_status_t st;
    start_boot();
    wait_rx_bytes(10);
    bus_write(cfg_pkg::REG_CTRL, 8'h02);
    @(posedge clk_master);
    #1;
    check_byte("v5c_prog_n_o after abort", {7'd0, v5c_prog_n}, 8'h00);
    repeat (4) @(posedge clk_master);  // INIT_B follows PROG_B through the synchronizer
    read_status(st);
    check_status("status after abort", st, status_of(1'b0, 1'b0, 1'b1, 1'b0));
    check_byte("mmc_cmd_o after abort", {7'd0, mmc_cmd}, 8'h01);
    run_full_boot();
  endtask

  task automatic double_start_boot();
    start_boot();
    wait_rx_bytes(5);
    bus_write(cfg_pkg::REG_CTRL, 8'h01);  // Must not restart the running boot
    expect_good_finish();
  endtask

  initial begin
    clk_master    = 1'b0;
    reset         = 1'b1;
    lb_stb        = 1'b0;
    lb_we         = 1'b0;
    lb_adr        = 3'd0;
    lb_dat_w      = 8'h00;
    init_wait     = 200;
    fail_after    = -1;
    cycles        = 0;
    mismatch_errs = 0;
    other_errs    = 0;
    verify_reset();
    run_full_boot();
    slow_init_boot();
    load_error_boot();
    host_abort_boot();
    double_start_boot();
    $display("Errors: %0d mismatches, %0d other failures", mismatch_errs, other_errs);
    if (mismatch_errs == 0 && other_errs == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* verif/tb_models.sv */
`timescale 1ns/10ps
`include "cfg_defs.svh"

// eMMC card in boot mode, a new byte on each rising card clock while CMD is low
module mmc_boot_model (
  input  logic       mmc_clk_i,
  input  logic       mmc_cmd_i,
  output logic [7:0] mmc_data_o
);

  logic [15:0] lfsr;
  logic [7:0]  next_byte;
  logic [7:0]  sent [`CFG_IMAGE_BYTES];  // Bytes presented during the current boot read
  int          sent_count;

  // Galois form of x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  initial begin
    lfsr       = 16'd99;
    next_byte  = 8'h00;
    mmc_data_o = 8'h00;
    sent_count = 0;
  end

  always @(negedge mmc_cmd_i) begin
    sent_count = 0;  // Host entered boot mode again
  end

  always @(posedge mmc_clk_i) begin
    if (!mmc_cmd_i) begin
      #1;
      for (int k = 0; k < 8; k++) begin
        next_byte = {next_byte[6:0], lfsr[0]};  // One LFSR step per bit
        lfsr      = lfsr_step(lfsr);
      end
      mmc_data_o = next_byte;
      if (sent_count < `CFG_IMAGE_BYTES) begin
        sent[sent_count] = next_byte;
      end
      sent_count++;
    end
  end

endmodule

// FPGA slave-serial port that releases INIT_B a set time after PROG_B rises
module fpga_ss_model (
  input  logic prog_n_i,
  input  logic cclk_i,
  input  logic din_i,
  input  int   init_wait_i,   // Nanoseconds from PROG_B rise to INIT_B rise
  input  int   fail_after_i,  // Pull INIT_B low after this many bytes, -1 for never
  output logic init_n_o,
  output logic done_o
);

  logic [7:0] rx_mem [`CFG_IMAGE_BYTES];
  logic [7:0] sr;
  int         rx_count;
  int         bit_count;
  int         cclk_count;

  initial begin
    init_n_o   = 1'b0;
    done_o     = 1'b0;
    sr         = 8'h00;
    rx_count   = 0;
    bit_count  = 0;
    cclk_count = 0;
  end

  always @(negedge prog_n_i) begin
    init_n_o = 1'b0;
    done_o   = 1'b0;
  end

  always @(posedge prog_n_i) begin
    rx_count   = 0;
    bit_count  = 0;
    cclk_count = 0;
    #(init_wait_i);
    if (prog_n_i) begin
      init_n_o = 1'b1;  // Configuration memory is clear
    end
  end

  always @(posedge cclk_i) begin
    cclk_count++;
    sr = {sr[6:0], din_i};  // MSB arrives first
    bit_count++;
    if (bit_count == 8) begin
      bit_count = 0;
      if (rx_count < `CFG_IMAGE_BYTES) begin
        rx_mem[rx_count] = sr;
        rx_count++;
        if (rx_count == fail_after_i) begin
          init_n_o = 1'b0;  // Load error seen by the FPGA
        end else if (rx_count == `CFG_IMAGE_BYTES && init_n_o) begin
          done_o = 1'b1;
        end
      end
    end
  end

endmodule
